// ==== list.f ====
+incdir+verilog
verilog/game_pkg.sv
verilog/board_pkg.sv
verilog/pattern_lfsr.sv
verilog/round_timer.sv
verilog/game_fsm.sv
verilog/level_display.sv
verilog/tone_gen.sv
verilog/memory_game_top.sv
bench/game_checker.sv
bench/tb_memory_game.sv

// ==== bench/game_tests.txt ====
// one entry per line: action, expected level, expected won, one hex digit each
// actions: 1 power on, 2 power off, 3 restart, 4 right, 5 wrong, 6 wait until dark
100
310
420
430
431
310
510
420
620
430
530
200
100
310
420
620
520
430

// ==== bench/tb_memory_game.sv ====
`default_nettype none

`include "game_macros.svh"

module tb_memory_game;

    localparam int NUM_TESTS   = 18;
    localparam int TEST_CYCLES = `ROUND_TICKS + `BEEP_CYCLES + 50;
    localparam int SETTLE      = 2 * `SCAN_DIV + 2;

    logic               clk;
    logic               sw;
    logic [7:0]         switches;
    logic               start;
    logic               restart;
    logic [15:0]        led;
    board_pkg::seg_t    seg;
    board_pkg::dig_t    dig;
    logic               beep;
    logic               check;
    game_pkg::level_t   exp_level;
    logic               exp_won;
    int                 checker_errors;
    int                 bench_errors;
    logic [11:0]        tests [0:NUM_TESTS-1];
    logic [31:0]        rng;
    int                 cycle = 0;
    int                 round_start;
    game_pkg::pattern_t answer;
    game_pkg::level_t   cur_level;

    memory_game_top i_memory_game_top
    (
        .clk      (clk),
        .sw       (sw),
        .switches (switches),
        .start    (start),
        .restart  (restart),
        .led      (led),
        .seg      (seg),
        .dig      (dig),
        .beep     (beep)
    );

    game_checker i_game_checker
    (
        .clk       (clk),
        .sw        (sw),
        .switches  (switches),
        .start     (start),
        .restart   (restart),
        .led       (led),
        .seg       (seg),
        .dig       (dig),
        .beep      (beep),
        .check     (check),
        .exp_level (exp_level),
        .exp_won   (exp_won),
        .errors    (checker_errors)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic pick_bit(input int width, output int idx);
        int value;
        value = 0;
        for (int k = 0; k < 3; k++)
        begin
            value = (value << 1) | rng[0];
            rng   = lfsr_step(rng);
        end
        idx = value % width;
    endtask

    // new round starts on the edge after restart
    task automatic press_restart();
        @(negedge clk);
        restart = 1'b1;
        @(negedge clk);
        restart     = 1'b0;
        round_start = cycle;
        answer      = led[6:0];
    endtask

    // judge takes one edge, the next round starts on the second
    task automatic submit_answer(input game_pkg::pattern_t value);
        @(negedge clk);
        switches[6:0] = value;
        start         = 1'b1;
        @(negedge clk);
        start = 1'b0;
        @(negedge clk);
        round_start = cycle;
        answer      = led[6:0];
    endtask

    task automatic run_test(input logic [11:0] t);
        int idx;
        if ($isunknown(t))
        begin
            bench_errors++;
            $display("tests file entry is missing or unreadable");
            return;
        end
        case (t[11:8])
            4'h1:
            begin
                @(negedge clk);
                switches[7] = 1'b1;
            end
            4'h2:
            begin
                @(negedge clk);
                switches = 8'd0;
            end
            4'h3: press_restart();
            4'h4: submit_answer(answer);
            4'h5:
            begin
                pick_bit(4 + cur_level, idx);
                submit_answer(answer ^ game_pkg::pattern_t'(1 << idx));
            end
            4'h6:
            begin
                while (cycle < round_start + `ROUND_TICKS)
                    @(negedge clk);
            end
            default:
            begin
                bench_errors++;
                $display("unknown action code %h in the tests file", t[11:8]);
            end
        endcase
        repeat (SETTLE) @(negedge clk);
        exp_level = t[5:4];
        exp_won   = t[0];
        check     = 1'b1;
        @(negedge clk);
        check     = 1'b0;
        cur_level = t[5:4];
    endtask

    initial
    begin
        sw           = 1'b0;
        switches     = 8'd0;
        start        = 1'b0;
        restart      = 1'b0;
        check        = 1'b0;
        exp_level    = 2'd0;
        exp_won      = 1'b0;
        bench_errors = 0;
        rng          = 32'hbe92;
        round_start  = 0;
        answer       = '0;
        cur_level    = 2'd0;
        $readmemh("bench/game_tests.txt", tests);
        repeat (8) @(negedge clk);
        sw = 1'b1;
        for (int i = 0; i < NUM_TESTS; i++)
        begin
            run_test(tests[i]);
        end
        @(negedge clk);
        $display("errors: checker %0d, bench %0d", checker_errors, bench_errors);
        if (checker_errors + bench_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    // watchdog
    initial
    begin
        repeat (NUM_TESTS * TEST_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", NUM_TESTS * TEST_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/game_checker.sv ====
`default_nettype none

`include "game_macros.svh"

module game_checker
(
    input  logic                    clk,
    input  logic                    sw,
    input  logic [7:0]              switches,
    input  logic                    start,
    input  logic                    restart,
    input  logic [15:0]             led,
    input  board_pkg::seg_t         seg,
    input  board_pkg::dig_t         dig,
    input  logic                    beep,
    input  logic                    check,
    input  game_pkg::level_t        exp_level,
    input  logic                    exp_won,
    output int                      errors
);

    // reference model of the game
    game_pkg::game_state_t m_state;
    game_pkg::level_t      m_level;
    game_pkg::ticks_t      m_ticks;
    game_pkg::pattern_t    m_pat;
    logic                  m_fresh;
    int                    beep_left;
    logic                  beep_seen;
    logic                  beep_fell;
    int                    dig_run;
    board_pkg::dig_t       last_dig;
    logic                  load;
    logic                  trig;
    int                    want;

    initial errors = 0;

    // 4 + level bits of the pattern are in play
    function automatic game_pkg::pattern_t level_mask(input game_pkg::level_t lvl);
        logic [7:0] m;
        m = (8'd1 << (4 + lvl)) - 8'd1;
        return m[6:0];
    endfunction

    // hex value of an active-low segment pattern or -1 for none
    function automatic int seg_digit(input board_pkg::seg_t s);
        case (~s[6:0])
            7'h3f: return 0;
            7'h06: return 1;
            7'h5b: return 2;
            7'h4f: return 3;
            7'h66: return 4;
            7'h6d: return 5;
            7'h7d: return 6;
            7'h07: return 7;
            7'h7f: return 8;
            7'h6f: return 9;
            7'h77: return 10;
            7'h7c: return 11;
            7'h39: return 12;
            7'h5e: return 13;
            7'h79: return 14;
            7'h71: return 15;
            default: return -1;
        endcase
    endfunction

    task automatic flag_mismatch(input string msg);
        errors++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    always @(posedge clk or negedge sw)
    begin
        if (!sw)
        begin
            m_state   = game_pkg::st_off;
            m_level   = 2'd0;
            m_ticks   = '0;
            m_pat     = '0;
            m_fresh   = 1'b0;
            beep_left = 0;
            beep_seen = 1'b0;
            beep_fell = 1'b0;
            dig_run   = 0;
            last_dig  = 2'b11;
        end
        else
        begin
            // led against the pattern window
            if (m_state == game_pkg::st_play && m_ticks != '0)
            begin
                if (m_fresh)
                begin
                    if (led[15:7] != '0 || (led[6:0] & ~level_mask(m_level)) != '0)
                        flag_mismatch($sformatf("led %h outside level %0d mask", led, m_level));
                    if (led == '0)
                        flag_mismatch($sformatf("level %0d pattern is dark", m_level));
                    m_pat   = led[6:0];
                    m_fresh = 1'b0;
                end
                else if (led !== {9'd0, m_pat & level_mask(m_level)})
                begin
                    flag_mismatch($sformatf("led %h, expected %h", led,
                        m_pat & level_mask(m_level)));
                end
            end
            else if (led !== 16'd0)
            begin
                flag_mismatch($sformatf("led %h lit outside the pattern window", led));
            end

            // display
            if (m_state == game_pkg::st_off || m_state == game_pkg::st_idle)
            begin
                if (seg !== 8'hff || dig !== 2'b11)
                    flag_mismatch($sformatf("display not blank, seg %h dig %b", seg, dig));
                dig_run = 0;
            end
            else if (dig === 2'b10 || dig === 2'b01)
            begin
                // each digit stays selected for one scan slot only
                dig_run = (dig === last_dig) ? dig_run + 1 : 1;
                if (dig_run > `SCAN_DIV)
                    flag_mismatch($sformatf("digit %b held for over %0d cycles", dig, `SCAN_DIV));
                if (dig === 2'b10)
                    want = (m_state == game_pkg::st_won) ? 14 : int'(m_level);
                else
                    want = int'(m_ticks[6:3]);
                if (seg_digit(seg) != want || seg[7] !== 1'b1)
                    flag_mismatch($sformatf("digit %b shows seg %h, expected %0h", dig, seg, want));
            end
            else
            begin
                flag_mismatch($sformatf("bad digit select %b", dig));
            end
            last_dig = dig;

            // the wave must rise and fall within one tone period of a trigger
            if (beep_left != 0)
            begin
                if (beep === 1'b1)
                    beep_seen = 1'b1;
                else if (beep_seen)
                    beep_fell = 1'b1;
                beep_left = beep_left - 1;
                if (beep_left == `BEEP_CYCLES - 2 * `TONE_HALF)
                begin
                    if (!beep_seen)
                        flag_mismatch("beep never went high after a trigger");
                    else if (!beep_fell)
                        flag_mismatch("beep did not toggle after a trigger");
                end
            end
            else if (beep !== 1'b0)
            begin
                flag_mismatch("beep high outside a beep window");
            end

            // progress expected by the tests file
            if (check && (m_level != exp_level || (m_state == game_pkg::st_won) != exp_won))
            begin
                flag_mismatch($sformatf("game at level %0d won %0d, expected level %0d won %0d",
                    m_level, m_state == game_pkg::st_won, exp_level, exp_won));
            end

            // advance the model
            load = 1'b0;
            trig = 1'b0;
            if (!switches[7])
            begin
                m_state = game_pkg::st_off;
                m_level = 2'd0;
            end
            else
            begin
                case (m_state)
                    game_pkg::st_off:
                    begin
                        m_state = game_pkg::st_idle;
                    end
                    game_pkg::st_idle:
                    begin
                        if (restart)
                        begin
                            m_state = game_pkg::st_play;
                            m_level = 2'd1;
                            load    = 1'b1;
                            m_fresh = 1'b1;
                        end
                    end
                    game_pkg::st_play:
                    begin
                        if (restart)
                        begin
                            m_level = 2'd1;
                            load    = 1'b1;
                        end
                        else if (start)
                        begin
                            m_state = game_pkg::st_judge;
                        end
                    end
                    game_pkg::st_judge:
                    begin
                        if (((switches[6:0] ^ m_pat) & level_mask(m_level)) != '0)
                        begin
                            m_state = game_pkg::st_play;
                            load    = 1'b1;
                            trig    = 1'b1;
                        end
                        else if (m_level == 2'd3)
                        begin
                            m_state = game_pkg::st_won;
                            trig    = 1'b1;
                        end
                        else
                        begin
                            m_state = game_pkg::st_play;
                            m_level = m_level + 2'd1;
                            load    = 1'b1;
                            m_fresh = 1'b1;
                        end
                    end
                    default:
                    begin
                        if (restart)
                        begin
                            m_state = game_pkg::st_play;
                            m_level = 2'd1;
                            load    = 1'b1;
                        end
                    end
                endcase
            end
            if (load)
                m_ticks = game_pkg::ticks_t'(`ROUND_TICKS);
            else if (m_ticks != '0)
                m_ticks = m_ticks - 7'd1;
            if (trig)
            begin
                beep_left = `BEEP_CYCLES;
                beep_seen = 1'b0;
                beep_fell = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/memory_game_top.sv ====
`default_nettype none

module memory_game_top
(
    input  logic              clk,
    input  logic              sw,
    input  logic [7:0]        switches,
    input  logic              start,
    input  logic              restart,
    output logic [15:0]       led,
    output board_pkg::seg_t   seg,
    output board_pkg::dig_t   dig,
    output logic              beep
);

    game_pkg::pattern_t      pattern;
    game_pkg::ticks_t        time_left;
    game_pkg::game_status_t  status;
    board_pkg::display_t     display;
    logic                    new_pattern;
    logic                    timer_load;
    logic                    shown_out;
    logic                    beep_trig;

    pattern_lfsr i_pattern_lfsr
    (
        .clk         (clk),
        .sw          (sw),
        .new_pattern (new_pattern),
        .pattern     (pattern)
    );

    round_timer i_round_timer
    (
        .clk        (clk),
        .sw         (sw),
        .timer_load (timer_load),
        .time_left  (time_left),
        .shown_out  (shown_out)
    );

    game_fsm i_game_fsm
    (
        .clk         (clk),
        .sw          (sw),
        .switches    (switches),
        .start       (start),
        .restart     (restart),
        .pattern     (pattern),
        .shown_out   (shown_out),
        .new_pattern (new_pattern),
        .timer_load  (timer_load),
        .beep_trig   (beep_trig),
        .status      (status),
        .led         (led)
    );

    level_display i_level_display
    (
        .clk       (clk),
        .sw        (sw),
        .status    (status),
        .time_left (time_left),
        .display   (display)
    );

    tone_gen i_tone_gen
    (
        .clk       (clk),
        .sw        (sw),
        .beep_trig (beep_trig),
        .beep      (beep)
    );

    // split the display bundle onto the board pins
    assign seg = display.seg;
    assign dig = display.dig;

endmodule

`default_nettype wire

// ==== verilog/tone_gen.sv ====
`default_nettype none

`include "game_macros.svh"

module tone_gen
(
    input  logic clk,
    input  logic sw,
    input  logic beep_trig,
    output logic beep
);

    localparam int DUR_W  = $clog2(`BEEP_CYCLES + 1);
    localparam int HALF_W = $clog2(`TONE_HALF + 1);

    logic [DUR_W-1:0]  dur;
    logic [HALF_W-1:0] half_cnt;

    always_ff @(posedge clk or negedge sw)
    begin
        if (!sw)
        begin
            dur      <= '0;
            half_cnt <= '0;
            beep     <= 1'b0;
        end
        else if (beep_trig)
        begin
            // a new trigger restarts the beep from the top
            dur      <= DUR_W'(`BEEP_CYCLES);
            half_cnt <= '0;
            beep     <= 1'b1;
        end
        else if (dur != '0)
        begin
            dur <= dur - 1'b1;
            if (dur == DUR_W'(1))
            begin
                beep <= 1'b0;
            end
            else if (half_cnt == HALF_W'(`TONE_HALF - 1))
            begin
                half_cnt <= '0;
                beep     <= ~beep;
            end
            else
            begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/level_display.sv ====
`default_nettype none

`include "game_macros.svh"

module level_display
(
    input  logic                    clk,
    input  logic                    sw,
    input  game_pkg::game_status_t  status,
    input  game_pkg::ticks_t        time_left,
    output board_pkg::display_t     display
);

    localparam int SCAN_W = $clog2(`SCAN_DIV);

    logic [SCAN_W-1:0] scan_cnt;
    logic              sel;
    logic [3:0]        nibble;
    logic [6:0]        code;

    // digit scan
    always_ff @(posedge clk or negedge sw)
    begin
        if (!sw)
        begin
            scan_cnt <= '0;
            sel      <= 1'b0;
        end
        else if (scan_cnt == SCAN_W'(`SCAN_DIV - 1))
        begin
            scan_cnt <= '0;
            sel      <= ~sel;
        end
        else
        begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // digit 0 is level or E, digit 1 is coarse time
    assign nibble = sel ? time_left[6:3] : (status.won ? 4'he : {2'b00, status.level});

    // gfedcba, active high here
    always_comb
    begin
        case (nibble)
            4'h0: code = 7'h3f;
            4'h1: code = 7'h06;
            4'h2: code = 7'h5b;
            4'h3: code = 7'h4f;
            4'h4: code = 7'h66;
            4'h5: code = 7'h6d;
            4'h6: code = 7'h7d;
            4'h7: code = 7'h07;
            4'h8: code = 7'h7f;
            4'h9: code = 7'h6f;
            4'ha: code = 7'h77;
            4'hb: code = 7'h7c;
            4'hc: code = 7'h39;
            4'hd: code = 7'h5e;
            4'he: code = 7'h79;
            default: code = 7'h71;
        endcase
    end

    // blank both digits when off or idle
    always_comb
    begin
        if (status.playing || status.won)
        begin
            display.seg = {1'b1, ~code};
            display.dig = sel ? 2'b01 : 2'b10;
        end
        else
        begin
            display.seg = 8'hff;
            display.dig = 2'b11;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/game_fsm.sv ====
`default_nettype none

module game_fsm
(
    input  logic                    clk,
    input  logic                    sw,
    input  logic [7:0]              switches,
    input  logic                    start,
    input  logic                    restart,
    input  game_pkg::pattern_t      pattern,
    input  logic                    shown_out,
    output logic                    new_pattern,
    output logic                    timer_load,
    output logic                    beep_trig,
    output game_pkg::game_status_t  status,
    output logic [15:0]             led
);

    game_pkg::game_state_t state;
    game_pkg::game_state_t next_state;
    game_pkg::level_t      level;
    game_pkg::level_t      next_level;
    game_pkg::pattern_t    mask;
    logic                  match;

    // 4 + level bits are in play
    always_comb
    begin
        case (level)
            2'd1:    mask = 7'b0011111;
            2'd2:    mask = 7'b0111111;
            2'd3:    mask = 7'b1111111;
            default: mask = 7'b0000000;
        endcase
    end

    assign match = ((switches[6:0] ^ pattern) & mask) == '0;

    always_comb
    begin
        next_state  = state;
        next_level  = level;
        new_pattern = 1'b0;
        timer_load  = 1'b0;
        beep_trig   = 1'b0;
        // power switch overrides everything
        if (!switches[7])
        begin
            next_state = game_pkg::st_off;
            next_level = 2'd0;
        end
        else
        begin
            case (state)
                game_pkg::st_off:
                begin
                    next_state = game_pkg::st_idle;
                end
                game_pkg::st_idle:
                begin
                    if (restart)
                    begin
                        next_state  = game_pkg::st_play;
                        next_level  = 2'd1;
                        new_pattern = 1'b1;
                        timer_load  = 1'b1;
                    end
                end
                game_pkg::st_play:
                begin
                    // restart keeps the pattern but drops to level 1
                    if (restart)
                    begin
                        next_level = 2'd1;
                        timer_load = 1'b1;
                    end
                    else if (start)
                    begin
                        next_state = game_pkg::st_judge;
                    end
                end
                game_pkg::st_judge:
                begin
                    if (match && level == 2'd3)
                    begin
                        next_state = game_pkg::st_won;
                        beep_trig  = 1'b1;
                    end
                    else if (match)
                    begin
                        next_state  = game_pkg::st_play;
                        next_level  = level + 2'd1;
                        new_pattern = 1'b1;
                        timer_load  = 1'b1;
                    end
                    else
                    begin
                        // replay same level, same pattern
                        next_state = game_pkg::st_play;
                        timer_load = 1'b1;
                        beep_trig  = 1'b1;
                    end
                end
                game_pkg::st_won:
                begin
                    if (restart)
                    begin
                        next_state = game_pkg::st_play;
                        next_level = 2'd1;
                        timer_load = 1'b1;
                    end
                end
                default:
                begin
                    next_state = game_pkg::st_off;
                    next_level = 2'd0;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge sw)
    begin
        if (!sw)
        begin
            state <= game_pkg::st_off;
            level <= 2'd0;
        end
        else
        begin
            state <= next_state;
            level <= next_level;
        end
    end

    always_comb
    begin
        status.level   = level;
        status.playing = (state == game_pkg::st_play) || (state == game_pkg::st_judge);
        status.won     = (state == game_pkg::st_won);
    end

    // lit only during the visible window of a round
    assign led = (state == game_pkg::st_play && !shown_out) ? {9'd0, pattern & mask} : 16'd0;

endmodule

`default_nettype wire

// ==== verilog/round_timer.sv ====
`default_nettype none

`include "game_macros.svh"

module round_timer
(
    input  logic              clk,
    input  logic              sw,
    input  logic              timer_load,
    output game_pkg::ticks_t  time_left,
    output logic              shown_out
);

    game_pkg::ticks_t count;

    // load on round start, then run down and park at zero
    always_ff @(posedge clk or negedge sw)
    begin
        if (!sw)
        begin
            count <= '0;
        end
        else if (timer_load)
        begin
            count <= game_pkg::ticks_t'(`ROUND_TICKS);
        end
        else if (count != '0)
        begin
            count <= count - 7'd1;
        end
    end

    assign time_left = count;

    // pattern window is over
    assign shown_out = (count == '0);

endmodule

`default_nettype wire

// ==== verilog/pattern_lfsr.sv ====
`default_nettype none

module pattern_lfsr
(
    input  logic                clk,
    input  logic                sw,
    input  logic                new_pattern,
    output game_pkg::pattern_t  pattern
);

    logic [15:0] lfsr;

    // galois form with taps 16 14 13 11
    always_ff @(posedge clk or negedge sw)
    begin
        if (!sw)
        begin
            lfsr <= 16'hace1;
        end
        else
        begin
            lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);
        end
    end

    // grab the low bits on request
    // level 1 sees only bits 4:0, so those must never all be dark
    always_ff @(posedge clk or negedge sw)
    begin
        if (!sw)
        begin
            pattern <= 7'd1;
        end
        else if (new_pattern)
        begin
            pattern <= (lfsr[4:0] == 5'd0) ? 7'd1 : lfsr[6:0];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/board_pkg.sv ====
`default_nettype none

package board_pkg;

    // segments a..g in bits 0..6, dp in bit 7, all active low
    typedef logic [7:0] seg_t;

    // digit selects, active low, bit 0 is the level digit
    typedef logic [1:0] dig_t;

    // everything the seven-segment module drives
    typedef struct packed
    {
        seg_t seg;
        dig_t dig;
    } display_t;

endpackage

`default_nettype wire

// ==== verilog/game_pkg.sv ====
`default_nettype none

package game_pkg;

    // top level game states
    typedef enum logic [2:0]
    {
        st_off,
        st_idle,
        st_play,
        st_judge,
        st_won
    } game_state_t;

    // pattern shown on the leds, also the player answer
    typedef logic [6:0] pattern_t;

    // 1 to 3 while playing, 0 when off or idle
    typedef logic [1:0] level_t;

    // round timer value
    typedef logic [6:0] ticks_t;

    // game progress as seen by the display
    typedef struct packed
    {
        level_t level;
        logic   playing;
        logic   won;
    } game_status_t;

endpackage

`default_nettype wire

// ==== verilog/game_macros.svh ====
`ifndef GAME_MACROS_SVH
`define GAME_MACROS_SVH

// cycles the pattern stays lit after a round starts
`define ROUND_TICKS 64

// length of one beep
`define BEEP_CYCLES 32

// half period of the beeper square wave
`define TONE_HALF 4

// cycles each display digit stays selected
`define SCAN_DIV 4

`endif
